// ==== build.f ====
+incdir+common
common/nf10_pkg.sv
hw/rx_queue/rx_queue.sv
hw/tx_queue/tx_queue.sv
hw/nf10_10g_interface.sv
test/nf10_10g_interface_assertions.sv
test/nf10_10g_interface_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module nf10_10g_interface_tb -o nf10_sim

out=$(./obj_dir/nf10_sim +verilator+error+limit+100) || true
echo "$out"
echo "$out" | grep -qx "Simulation passed"

// ==== test/nf10_10g_interface_tb.sv ====
// Testbench for the 10G port interface: clock, reset, MAC model,
// frame table with payload LFSR, checks, watchdog and summary
`timescale 1ns/1ps

module nf10_10g_interface_tb;

    typedef struct {
        string      name;
        bit         is_tx;
        int         len;
        bit         good;
        logic [7:0] ready_pat;
    } frame_test_t;

    logic                 axi_aclk = 1'b0;
    logic                 rst_n;
    nf10_pkg::axis_beat_t m_axis_beat;
    logic                 m_axis_valid;
    logic                 m_axis_ready;
    nf10_pkg::axis_beat_t s_axis_beat;
    logic                 s_axis_valid;
    logic                 s_axis_ready;
    nf10_pkg::mac_beat_t  rx_word;
    logic                 rx_good_frame;
    logic                 rx_bad_frame;
    nf10_pkg::mac_beat_t  tx_word;
    logic                 tx_start;
    logic                 tx_ack;

    frame_test_t tests[$];
    logic [7:0]  frame_bytes[$];
    logic [15:0] lfsr = 16'd40438;
    int          test_errors = 0;
    int          mismatches = 0;
    int          failed_tests = 0;

    nf10_10g_interface dut (.*);

    always #20 axi_aclk = ~axi_aclk;

    //////////////////////////////////////////////////
    // Payload and expected words
    //////////////////////////////////////////////////

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic fill_bytes(input int n);
        logic [7:0] b;
        frame_bytes.delete();
        for (int i = 0; i < n; i++) begin
            for (int j = 0; j < 8; j++) begin
                b = {b[6:0], lfsr[15]};
                lfsr = lfsr_next(lfsr);
            end
            frame_bytes.push_back(b);
        end
    endtask

    // Byte i of the word sits in bits 8i+7:8i, unused bytes zero
    function automatic nf10_pkg::data_t word_data(input int k);
        nf10_pkg::data_t d;
        d = '0;
        for (int i = 0; i < 8; i++) begin
            if (8 * k + i < frame_bytes.size()) begin
                d[8*i +: 8] = frame_bytes[8 * k + i];
            end
        end
        return d;
    endfunction

    function automatic nf10_pkg::strb_t word_mask(input int k);
        int rem;
        rem = frame_bytes.size() - 8 * k;
        return (rem >= 8) ? 8'hff : 8'hff >> (8 - rem);
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [127:0] expected, input logic [127:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s %s expected %0h actual %0h", name, what, expected, actual);
            test_errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // Receive path, testbench as MAC and host
    //////////////////////////////////////////////////

    task automatic run_rx(input frame_test_t t);
        int nwords;
        int k;
        int cyc;
        nwords = (t.len + 7) / 8;
        fill_bytes(t.len);
        for (int w = 0; w < nwords; w++) begin
            @(posedge axi_aclk);
            rx_word <= {word_data(w), word_mask(w)};
        end
        @(posedge axi_aclk);
        rx_word       <= '0;
        rx_good_frame <= t.good;
        rx_bad_frame  <= !t.good;
        @(posedge axi_aclk);
        rx_good_frame <= 1'b0;
        rx_bad_frame  <= 1'b0;
        if (!t.good) begin
            // Dropped frame must never reach the host
            repeat (8) begin
                @(posedge axi_aclk);
                check_value(t.name, "m_axis_valid", 128'(0), 128'(m_axis_valid));
            end
        end else begin
            k = 0;
            cyc = 0;
            while (k < nwords) begin
                @(posedge axi_aclk);
                if (m_axis_valid && m_axis_ready) begin
                    check_value(t.name, "tdata", 128'(word_data(k)), 128'(m_axis_beat.data));
                    check_value(t.name, "tstrb", 128'(word_mask(k)), 128'(m_axis_beat.strb));
                    check_value(t.name, "tuser",
                                (k == 0) ? {96'd0, 8'h00, 8'h01, 16'(t.len)} : 128'(0),
                                m_axis_beat.user);
                    check_value(t.name, "tlast", 128'(k == nwords - 1),
                                128'(m_axis_beat.last));
                    k++;
                end
                m_axis_ready <= t.ready_pat[cyc % 8];
                cyc++;
            end
            m_axis_ready <= 1'b0;
        end
    endtask

    //////////////////////////////////////////////////
    // Transmit path
    //////////////////////////////////////////////////

    task automatic run_tx(input frame_test_t t);
        int nwords;
        nwords = (t.len + 7) / 8;
        fill_bytes(t.len);
        @(posedge axi_aclk);
        for (int w = 0; w < nwords; w++) begin
            s_axis_beat  <= {word_data(w), word_mask(w), 128'(0), w == nwords - 1};
            s_axis_valid <= 1'b1;
            @(posedge axi_aclk);
            while (!s_axis_ready) begin
                @(posedge axi_aclk);
            end
        end
        s_axis_valid <= 1'b0;
        @(posedge axi_aclk);
        check_value(t.name, "tx_start", 128'(1), 128'(tx_start));
        check_value(t.name, "s_axis_ready", 128'(0), 128'(s_axis_ready));
        // MAC lets the request wait a little
        repeat (3) @(posedge axi_aclk);
        tx_ack <= 1'b1;
        @(posedge axi_aclk);
        tx_ack <= 1'b0;
        for (int w = 0; w < nwords; w++) begin
            @(posedge axi_aclk);
            check_value(t.name, "tx data", 128'(word_data(w)), 128'(tx_word.data));
            check_value(t.name, "tx mask", 128'(word_mask(w)), 128'(tx_word.valid));
            check_value(t.name, "s_axis_ready", 128'(0), 128'(s_axis_ready));
        end
        @(posedge axi_aclk);
        check_value(t.name, "idle tx mask", 128'(0), 128'(tx_word.valid));
        check_value(t.name, "tx_start", 128'(0), 128'(tx_start));
        check_value(t.name, "s_axis_ready", 128'(1), 128'(s_axis_ready));
    endtask

    task automatic add_test(input string name, input bit is_tx, input int len,
                            input bit good, input logic [7:0] ready_pat);
        frame_test_t t;
        t = '{name, is_tx, len, good, ready_pat};
        tests.push_back(t);
    endtask

    task automatic watchdog(input int cycles);
        repeat (cycles) @(posedge axi_aclk);
        $display("Watchdog: the run timed out after %0d cycles", cycles);
        $display("Simulation failed");
        $finish;
    endtask

    initial begin
        int total_words;
        rst_n = 1'b0;
        m_axis_ready = 1'b0;
        s_axis_beat = '0;
        s_axis_valid = 1'b0;
        rx_word = '0;
        rx_good_frame = 1'b0;
        rx_bad_frame = 1'b0;
        tx_ack = 1'b0;

        add_test("rx_full_64", 1'b0, 64, 1'b1, 8'hff);
        add_test("rx_odd_37", 1'b0, 37, 1'b1, 8'hff);
        add_test("rx_bad_20", 1'b0, 20, 1'b0, 8'hff);
        add_test("rx_after_bad_45", 1'b0, 45, 1'b1, 8'b1011_0010);
        add_test("rx_single_3", 1'b0, 3, 1'b1, 8'b0101_0101);
        add_test("rx_long_200", 1'b0, 200, 1'b1, 8'b1100_1110);
        add_test("tx_frame_30", 1'b1, 30, 1'b1, 8'hff);
        add_test("tx_frame_64", 1'b1, 64, 1'b1, 8'hff);
        add_test("tx_frame_9", 1'b1, 9, 1'b1, 8'hff);

        total_words = 0;
        foreach (tests[i]) begin
            total_words += (tests[i].len + 7) / 8;
        end
        fork
            watchdog(total_words * 20 + 100);
        join_none

        repeat (2) @(posedge axi_aclk);
        rst_n <= 1'b1;

        foreach (tests[i]) begin
            test_errors = 0;
            if (tests[i].is_tx) begin
                run_tx(tests[i]);
            end else begin
                run_rx(tests[i]);
            end
            if (test_errors == 0) begin
                $display("test %-16s ok", tests[i].name);
            end else begin
                $display("test %-16s %0d mismatches", tests[i].name, test_errors);
                failed_tests++;
            end
            mismatches += test_errors;
        end
        if (dut.handshake_checks.failures != 0) begin
            $display("Handshake assertions failed %0d times", dut.handshake_checks.failures);
            failed_tests++;
        end
        $display("%0d tests, %0d failed, %0d mismatches", tests.size(), failed_tests, mismatches);
        if (failed_tests == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== test/nf10_10g_interface_assertions.sv ====
// Concurrent checks on the host receive stream and the MAC transmit request
// Bound into the interface top
`timescale 1ns/1ps

module nf10_10g_interface_assertions (
    input logic                 axi_aclk,
    input logic                 rst_n,
    input nf10_pkg::axis_beat_t m_axis_beat,
    input logic                 m_axis_valid,
    input logic                 m_axis_ready,
    input nf10_pkg::mac_beat_t  tx_word,
    input logic                 tx_start,
    input logic                 tx_ack
);

    int unsigned failures = 0;

    // Stalled beat holds until the host takes it
    beat_hold: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        m_axis_valid && !m_axis_ready |=> m_axis_valid && $stable(m_axis_beat))
        else begin
            $error("m_axis beat changed while stalled");
            failures++;
        end

    // Request stays up until the MAC acknowledges
    start_hold: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        tx_start && !tx_ack |=> tx_start)
        else begin
            $error("tx_start dropped before tx_ack");
            failures++;
        end

    // Words come only after an acknowledged request and never while it is pending
    no_word_pending: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        (tx_word.valid != '0) |-> !tx_start
            && ($past(tx_start && tx_ack) || $past(tx_word.valid != '0)))
        else begin
            $error("tx word sent while tx_start is pending or without tx_ack");
            failures++;
        end

endmodule

bind nf10_10g_interface nf10_10g_interface_assertions handshake_checks (
    .axi_aclk     (axi_aclk),
    .rst_n        (rst_n),
    .m_axis_beat  (m_axis_beat),
    .m_axis_valid (m_axis_valid),
    .m_axis_ready (m_axis_ready),
    .tx_word      (tx_word),
    .tx_start     (tx_start),
    .tx_ack       (tx_ack)
);

// ==== hw/nf10_10g_interface.sv ====
// 10G port interface top: receive queue toward the host stream,
// transmit queue toward the MAC
`timescale 1ns/1ps

module nf10_10g_interface #(
    parameter nf10_pkg::port_t src_port = 8'h01
) (
    input  logic                 axi_aclk,
    input  logic                 rst_n,

    // Host receive stream
    output nf10_pkg::axis_beat_t m_axis_beat,
    output logic                 m_axis_valid,
    input  logic                 m_axis_ready,

    // Host transmit stream
    input  nf10_pkg::axis_beat_t s_axis_beat,
    input  logic                 s_axis_valid,
    output logic                 s_axis_ready,

    // MAC receive
    input  nf10_pkg::mac_beat_t  rx_word,
    input  logic                 rx_good_frame,
    input  logic                 rx_bad_frame,

    // MAC transmit
    output nf10_pkg::mac_beat_t  tx_word,
    output logic                 tx_start,
    input  logic                 tx_ack
);

    //////////////////////////////////////////////////
    // Queues
    //////////////////////////////////////////////////

    rx_queue rx_queue (
        .axi_aclk      (axi_aclk),
        .rst_n         (rst_n),
        .src_port      (src_port),
        .rx_word       (rx_word),
        .rx_good_frame (rx_good_frame),
        .rx_bad_frame  (rx_bad_frame),
        .m_beat        (m_axis_beat),
        .m_valid       (m_axis_valid),
        .m_ready       (m_axis_ready)
    );

    tx_queue tx_queue (
        .axi_aclk (axi_aclk),
        .rst_n    (rst_n),
        .s_beat   (s_axis_beat),
        .s_valid  (s_axis_valid),
        .s_ready  (s_axis_ready),
        .tx_word  (tx_word),
        .tx_start (tx_start),
        .tx_ack   (tx_ack)
    );

endmodule

// ==== hw/tx_queue/tx_queue.sv ====
// Transmit queue: store-and-forward frame buffer and the
// start/ack request FSM toward the MAC
`timescale 1ns/1ps
`include "nf10_defines.svh"

module tx_queue (
    input  logic                 axi_aclk,
    input  logic                 rst_n,
    input  nf10_pkg::axis_beat_t s_beat,
    input  logic                 s_valid,
    output logic                 s_ready,
    output nf10_pkg::mac_beat_t  tx_word,
    output logic                 tx_start,
    input  logic                 tx_ack
);

    localparam int WA = $clog2(`NF10_MAX_FRAME_WORDS);
    localparam logic [WA:0] MAX_WORDS = `NF10_MAX_FRAME_WORDS;

    nf10_pkg::mac_beat_t frame_mem [`NF10_MAX_FRAME_WORDS];
    nf10_pkg::mac_beat_t in_word;
    nf10_pkg::tx_state_e state;

    // Words stored in the current frame, and words already sent
    logic [WA:0] wr_cnt;
    logic [WA:0] rd_cnt;

    logic accept;
    logic store;

    //////////////////////////////////////////////////
    // Host side
    //////////////////////////////////////////////////

    assign s_ready = (state == nf10_pkg::IDLE) || (state == nf10_pkg::FILL);
    assign accept  = s_valid && s_ready;

    // Words past the buffer size are dropped, tuser is not kept
    assign store = accept && (wr_cnt != MAX_WORDS);

    assign in_word.data  = s_beat.data;
    assign in_word.valid = s_beat.strb;

    always_ff @(posedge axi_aclk) begin
        if (store) begin
            frame_mem[wr_cnt[WA-1:0]] <= in_word;
        end
    end

    //////////////////////////////////////////////////
    // MAC side
    //////////////////////////////////////////////////

    assign tx_start = state == nf10_pkg::REQUEST;

    // Mask stays zero outside a frame
    assign tx_word = (state == nf10_pkg::SEND) ? frame_mem[rd_cnt[WA-1:0]] : '0;

    always_ff @(posedge axi_aclk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= nf10_pkg::IDLE;
            wr_cnt <= '0;
            rd_cnt <= '0;
        end else begin
            case (state)
                nf10_pkg::IDLE, nf10_pkg::FILL: begin
                    if (store) begin
                        wr_cnt <= wr_cnt + 1'b1;
                    end
                    if (accept) begin
                        state <= s_beat.last ? nf10_pkg::REQUEST : nf10_pkg::FILL;
                    end
                end
                nf10_pkg::REQUEST: begin
                    // Hold the request until the MAC takes it
                    if (tx_ack) begin
                        state <= nf10_pkg::SEND;
                    end
                end
                nf10_pkg::SEND: begin
                    if (rd_cnt == wr_cnt - 1'b1) begin
                        state  <= nf10_pkg::IDLE;
                        wr_cnt <= '0;
                        rd_cnt <= '0;
                    end else begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= nf10_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hw/rx_queue/rx_queue.sv ====
// Receive queue: MAC word buffer with per-frame commit or rewind,
// frame length FIFO and AXI stream output with tuser metadata
`timescale 1ns/1ps
`include "nf10_defines.svh"

module rx_queue (
    input  logic                 axi_aclk,
    input  logic                 rst_n,
    input  nf10_pkg::port_t      src_port,
    input  nf10_pkg::mac_beat_t  rx_word,
    input  logic                 rx_good_frame,
    input  logic                 rx_bad_frame,
    output nf10_pkg::axis_beat_t m_beat,
    output logic                 m_valid,
    input  logic                 m_ready
);

    localparam int AW = $clog2(`NF10_RX_DEPTH);
    localparam int FW = $clog2(`NF10_RX_FRAMES);
    localparam logic [AW:0] DEPTH = `NF10_RX_DEPTH;
    localparam logic [FW:0] FRAMES = `NF10_RX_FRAMES;

    nf10_pkg::mac_beat_t word_mem [`NF10_RX_DEPTH];
    nf10_pkg::pkt_len_t  len_mem [`NF10_RX_FRAMES];

    // Pointers carry one extra wrap bit
    logic [AW:0] wr_ptr;
    logic [AW:0] commit_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] base_ptr;
    logic [FW:0] len_wr;
    logic [FW:0] len_rd;

    nf10_pkg::pkt_len_t  frame_len;
    nf10_pkg::pkt_len_t  base_len;
    nf10_pkg::pkt_len_t  len_head;
    nf10_pkg::pkt_len_t  len_words;
    nf10_pkg::pkt_len_t  cur_len;
    nf10_pkg::user_t     meta;
    nf10_pkg::mac_beat_t rd_word;

    logic drop_frame, base_drop, frame_end, commit_ok;
    logic word_in, word_wr, buf_full, len_full, len_empty;
    logic active, first_beat, pop, load;
    logic [AW:0] words_left;

    function automatic nf10_pkg::pkt_len_t byte_count(input nf10_pkg::strb_t mask);
        nf10_pkg::pkt_len_t n;
        n = '0;
        for (int i = 0; i < $bits(mask); i++) begin
            n = n + nf10_pkg::pkt_len_t'(mask[i]);
        end
        return n;
    endfunction

    //////////////////////////////////////////////////
    // MAC side write
    //////////////////////////////////////////////////

    assign frame_end = rx_good_frame || rx_bad_frame;
    assign len_full  = (len_wr - len_rd) == FRAMES;
    assign len_empty = len_wr == len_rd;
    assign commit_ok = rx_good_frame && !drop_frame && !len_full && (frame_len != '0);

    // Where the next word lands; a rejected frame rewinds to the commit point
    assign base_ptr  = (frame_end && !commit_ok) ? commit_ptr : wr_ptr;
    assign base_len  = frame_end ? '0 : frame_len;
    assign base_drop = frame_end ? 1'b0 : drop_frame;

    assign word_in  = |rx_word.valid;
    assign buf_full = (base_ptr - rd_ptr) == DEPTH;
    assign word_wr  = word_in && !base_drop && !buf_full;

    always_ff @(posedge axi_aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            frame_len  <= '0;
            drop_frame <= 1'b0;
            len_wr     <= '0;
        end else begin
            wr_ptr     <= base_ptr + {{AW{1'b0}}, word_wr};
            frame_len  <= word_wr ? base_len + byte_count(rx_word.valid) : base_len;
            // Once a word is lost the rest of the frame goes too
            drop_frame <= base_drop || (word_in && !word_wr);
            if (commit_ok) begin
                commit_ptr <= wr_ptr;
                len_wr     <= len_wr + 1'b1;
            end
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (word_wr) begin
            word_mem[base_ptr[AW-1:0]] <= rx_word;
        end
        if (commit_ok) begin
            len_mem[len_wr[FW-1:0]] <= frame_len;
        end
    end

    //////////////////////////////////////////////////
    // AXI stream read
    //////////////////////////////////////////////////

    assign len_head  = len_mem[len_rd[FW-1:0]];
    assign len_words = (len_head + 16'd7) >> 3;
    assign rd_word   = word_mem[rd_ptr[AW-1:0]];
    assign pop       = !active && !len_empty;
    assign load      = active && (!m_valid || m_ready);

    // Length, source port, zero destination port
    assign meta = {{(`NF10_TUSER_WIDTH-32){1'b0}}, 8'h00, src_port, cur_len};

    always_ff @(posedge axi_aclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr     <= '0;
            len_rd     <= '0;
            active     <= 1'b0;
            first_beat <= 1'b0;
            words_left <= '0;
            m_valid    <= 1'b0;
        end else begin
            if (pop) begin
                active     <= 1'b1;
                first_beat <= 1'b1;
                words_left <= len_words[AW:0];
                len_rd     <= len_rd + 1'b1;
            end
            if (load) begin
                rd_ptr     <= rd_ptr + 1'b1;
                words_left <= words_left - 1'b1;
                first_beat <= 1'b0;
                if (words_left == 1) begin
                    active <= 1'b0;
                end
            end
            if (load) begin
                m_valid <= 1'b1;
            end else if (m_ready) begin
                m_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (pop) begin
            cur_len <= len_head;
        end
        if (load) begin
            m_beat.data <= rd_word.data;
            m_beat.strb <= rd_word.valid;
            m_beat.user <= first_beat ? meta : '0;
            m_beat.last <= words_left == 1;
        end
    end

endmodule

// ==== common/nf10_pkg.sv ====
// Width typedefs, stream beat structs and transmit FSM states
// for the 10G port interface

`include "nf10_defines.svh"

package nf10_pkg;

    //////////////////////////////////////////////////
    // Widths with a meaning
    //////////////////////////////////////////////////

    typedef logic [63:0] data_t;

    // Byte mask, bit i set for byte i, contiguous from bit 0
    typedef logic [7:0] strb_t;

    typedef logic [`NF10_TUSER_WIDTH-1:0] user_t;

    // Frame length in bytes
    typedef logic [15:0] pkt_len_t;

    // One-hot port mask
    typedef logic [7:0] port_t;

    //////////////////////////////////////////////////
    // Beats
    //////////////////////////////////////////////////

    // One AXI stream transfer
    typedef struct packed {
        data_t data;
        strb_t strb;
        user_t user;
        logic  last;
    } axis_beat_t;

    // One MAC word, no word when the mask is zero
    typedef struct packed {
        data_t data;
        strb_t valid;
    } mac_beat_t;

    typedef enum logic [1:0] {IDLE, FILL, REQUEST, SEND} tx_state_e;

endpackage

// ==== common/nf10_defines.svh ====
// Buffer depths and frame size limits for the 10G port queues
// Shared by the package and both queue modules

`ifndef NF10_DEFINES_SVH
`define NF10_DEFINES_SVH

//////////////////////////////////////////////////
// Receive side
//////////////////////////////////////////////////

// Words held by the receive buffer
`define NF10_RX_DEPTH 64

// Committed frames waiting for the host
`define NF10_RX_FRAMES 8

//////////////////////////////////////////////////
// Transmit side and metadata
//////////////////////////////////////////////////

`define NF10_MAX_FRAME_WORDS 32
`define NF10_TUSER_WIDTH 128

`endif
